//--- flist.f
+incdir+source
source/arena_pkg.sv
source/vga_timing.sv
source/game_state_regs.sv
source/player_layer.sv
source/pixel_mixer.sv
source/seven_seg_decoder.sv
source/arena_top.sv
dv/arena_tb.sv

//--- dv/arena_tb.sv
// Arena testbench
// Directed tests against a raster reference model of the pixel datapath
`timescale 1ns/1ps
`include "arena_defs.svh"

module arena_tb import arena_pkg::*; ();

    localparam int FRAME_CYC    = `H_TOTAL * `V_TOTAL;
    localparam int N_TESTS      = 5;
    localparam int WATCHDOG_CYC = N_TESTS * 4 * FRAME_CYC + 2000;

    logic        Clk;
    logic        arst_n;
    logic        reg_we;
    logic [4:0]  reg_addr;
    arena_word_u reg_wdata;
    logic [7:0]  vga_r, vga_g, vga_b;
    logic        vga_hs, vga_vs, vga_blank_n;
    logic [6:0]  hex0, hex1;

    int n_checks;
    int n_errors;
    int edge_cnt;                // Rising edges since reset release
    int pts [64];                // Raster keys y*H_TOTAL+x to sample
    int n_pts;

    // Shadow of the register file with player 1 at index 0
    coord_t     sh_ship_x [2];
    coord_t     sh_ship_y [2];
    coord_t     sh_torp_x [2][`N_TORP];
    coord_t     sh_torp_y [2][`N_TORP];
    logic [3:0] sh_off [2];

    arena_top u_arena_top (
        .Clk(Clk), .arst_n(arst_n), .reg_we(reg_we), .reg_addr(reg_addr),
        .reg_wdata(reg_wdata), .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b),
        .vga_hs(vga_hs), .vga_vs(vga_vs), .vga_blank_n(vga_blank_n),
        .hex0(hex0), .hex1(hex1)
    );

    initial begin
        Clk = 1'b0;
        forever #4 Clk = ~Clk;
    end

    always @(posedge Clk or negedge arst_n) begin
        if (!arst_n)
            edge_cnt <= 0;
        else
            edge_cnt <= edge_cnt + 1;
    end

    // --------------------
    // Reference model
    function automatic logic in_box(input int px, py, bx, by, size);
        return (px >= bx) && (px < bx + size) && (py >= by) && (py < by + size);
    endfunction

    function automatic logic [23:0] model_rgb(input int x, y);
        logic t_hit [2];
        for (int p = 0; p < 2; p++) begin
            t_hit[p] = 1'b0;
            for (int i = 0; i < `N_TORP; i++)
                if (!sh_off[p][i] && in_box(x, y, sh_torp_x[p][i], sh_torp_y[p][i], `TORP_SIZE))
                    t_hit[p] = 1'b1;
        end
        if (!((x < `H_VISIBLE) && (y < `V_VISIBLE)))
            return 24'h000000;
        else if (in_box(x, y, sh_ship_x[0], sh_ship_y[0], `SHIP_SIZE))
            return `COLOR_SHIP1;
        else if (in_box(x, y, sh_ship_x[1], sh_ship_y[1], `SHIP_SIZE))
            return `COLOR_SHIP2;
        else if (t_hit[0])
            return `COLOR_TORP1;
        else if (t_hit[1])
            return `COLOR_TORP2;
        return `COLOR_BG;
    endfunction

    // {hs, vs, blank_n}
    function automatic logic [2:0] model_sync(input int x, y);
        logic hs, vs, bl;
        hs = !((x >= `H_VISIBLE + `H_FRONT) && (x < `H_VISIBLE + `H_FRONT + `H_SYNC));
        vs = !((y >= `V_VISIBLE + `V_FRONT) && (y < `V_VISIBLE + `V_FRONT + `V_SYNC));
        bl = (x < `H_VISIBLE) && (y < `V_VISIBLE);
        return {hs, vs, bl};
    endfunction

    // Lit segments g..a inverted for the active-low pins
    function automatic logic [6:0] seg_pattern(input logic [3:0] n);
        logic [6:0] lit;
        case (n)
            4'h0: lit = 7'h3F;
            4'h1: lit = 7'h06;
            4'h2: lit = 7'h5B;
            4'h3: lit = 7'h4F;
            4'h4: lit = 7'h66;
            4'h5: lit = 7'h6D;
            4'h6: lit = 7'h7D;
            4'h7: lit = 7'h07;
            4'h8: lit = 7'h7F;
            4'h9: lit = 7'h6F;
            4'hA: lit = 7'h77;
            4'hB: lit = 7'h7C;
            4'hC: lit = 7'h39;
            4'hD: lit = 7'h5E;
            4'hE: lit = 7'h79;
            default: lit = 7'h71;
        endcase
        return ~lit;
    endfunction

    function automatic logic [3:0] seg_value(input logic [6:0] seg);
        logic [3:0] v;
        v = 4'h0;
        for (int n = 0; n < 16; n++)
            if (seg_pattern(4'(n)) == seg)
                v = 4'(n);
        return v;
    endfunction

    // --------------------
    // Compare tasks
    task automatic check_rgb(input string name, input logic [23:0] got, exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("** Error: %s got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_sync(input string name, input logic [2:0] got, exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("** Error: %s got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_coord(input string name, input coord_t got, exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("** Error: %s got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_seg(input string name, input logic [6:0] got, exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("** Error: %s got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // --------------------
    // Bus and raster helpers
    task automatic write_reg(input logic [4:0] addr, input arena_word_u w);
        @(negedge Clk);
        reg_we    = 1'b1;
        reg_addr  = addr;
        reg_wdata = w;
        @(negedge Clk);
        reg_we    = 1'b0;
    endtask

    task automatic write_ship(input int p, input coord_t x, y);
        arena_word_u w;
        w.coord = x;
        write_reg(p ? `ADDR_SHIP2_X : `ADDR_SHIP1_X, w);
        w.coord = y;
        write_reg(p ? `ADDR_SHIP2_Y : `ADDR_SHIP1_Y, w);
        sh_ship_x[p] = x;
        sh_ship_y[p] = y;
    endtask

    task automatic write_torp(input int p, i, input coord_t x, y);
        arena_word_u w;
        w.coord = x;
        write_reg(5'((p ? `ADDR_TORP2_X : `ADDR_TORP1_X) + i), w);
        w.coord = y;
        write_reg(5'((p ? `ADDR_TORP2_Y : `ADDR_TORP1_Y) + i), w);
        sh_torp_x[p][i] = x;
        sh_torp_y[p][i] = y;
    endtask

    task automatic write_mask(input int p, input logic [3:0] m);
        arena_word_u w;
        w = '0;
        w.mask.torp_off = m;      // Mask view of the same word
        write_reg(p ? `ADDR_MASK2 : `ADDR_MASK1, w);
        sh_off[p] = m;
    endtask

    task automatic wait_pixel(input int key);
        logic found;
        found = 1'b0;
        for (int n = 0; n < FRAME_CYC + 4 && !found; n++) begin
            @(negedge Clk);
            if (edge_cnt >= 1 && ((edge_cnt - 1) % FRAME_CYC) == key)
                found = 1'b1;
        end
        if (!found) begin
            n_errors++;
            $display("Raster never reached pixel %0d within one frame", key);
        end
    endtask

    task automatic add_point(input int x, y);
        pts[n_pts] = y * `H_TOTAL + x;
        n_pts++;
    endtask

    // Sort into raster order so one frame covers all points
    task automatic visit_points();
        int tmp, x, y;
        for (int i = 1; i < n_pts; i++)
            for (int j = i; j > 0 && pts[j-1] > pts[j]; j--) begin
                tmp      = pts[j];
                pts[j]   = pts[j-1];
                pts[j-1] = tmp;
            end
        for (int i = 0; i < n_pts; i++) begin
            if (i > 0 && pts[i] == pts[i-1])
                continue;
            x = pts[i] % `H_TOTAL;
            y = pts[i] / `H_TOTAL;
            wait_pixel(pts[i]);
            check_rgb($sformatf("{vga_r,vga_g,vga_b} at (%0d,%0d)", x, y),
                      {vga_r, vga_g, vga_b}, model_rgb(x, y));
            check_sync($sformatf("{vga_hs,vga_vs,vga_blank_n} at (%0d,%0d)", x, y),
                       {vga_hs, vga_vs, vga_blank_n}, model_sync(x, y));
        end
        n_pts = 0;
    endtask

    task automatic report_test(input string name, input int c0, e0);
        $display("Test %s finished: %0d checks, %0d errors", name, n_checks - c0,
                 n_errors - e0);
    endtask

    // --------------------
    // Tests
    task automatic test_reset_sync();
        int c0, e0, x, y;
        c0 = n_checks;
        e0 = n_errors;
        repeat (8) begin
            @(negedge Clk);
            check_rgb("{vga_r,vga_g,vga_b} in reset", {vga_r, vga_g, vga_b}, 24'h000000);
            check_sync("{vga_hs,vga_vs,vga_blank_n} in reset",
                       {vga_hs, vga_vs, vga_blank_n}, 3'b110);
            check_seg("hex0 in reset", hex0, seg_pattern(4'h0));
            check_seg("hex1 in reset", hex1, seg_pattern(4'h0));
        end
        arst_n = 1'b1;
        for (int n = 0; n < FRAME_CYC; n++) begin
            @(negedge Clk);
            x = (edge_cnt - 1) % `H_TOTAL;
            y = ((edge_cnt - 1) / `H_TOTAL) % `V_TOTAL;
            check_sync($sformatf("{vga_hs,vga_vs,vga_blank_n} at (%0d,%0d)", x, y),
                       {vga_hs, vga_vs, vga_blank_n}, model_sync(x, y));
        end
        report_test("reset_sync", c0, e0);
    endtask

    task automatic test_background();
        int c0, e0;
        c0 = n_checks;
        e0 = n_errors;
        add_point(0, 0);          // Ship 1 box over the torpedoes at the origin
        add_point(5, 5);
        add_point(320, 240);
        add_point(100, 400);
        add_point(639, 479);
        add_point(700, 10);
        add_point(645, 100);
        add_point(10, 500);
        visit_points();
        report_test("background", c0, e0);
    endtask

    task automatic test_ship_priority();
        int c0, e0, x1, y1, x2, y2;
        c0 = n_checks;
        e0 = n_errors;
        x1 = 20 + $urandom % 500;
        y1 = 20 + $urandom % 380;
        x2 = x1 + 1 + $urandom % 30;   // Always overlaps ship 1
        y2 = y1 + 1 + $urandom % 30;
        write_ship(0, coord_t'(x1), coord_t'(y1));
        write_ship(1, coord_t'(x2), coord_t'(y2));
        add_point(x1, y1);
        add_point(x1 - 1, y1);
        add_point(x1, y1 - 1);
        add_point(x1 + 39, y1 + 39);
        add_point(x2, y1 + 39);
        add_point(x1 + 39, y1 + 40);
        add_point(x1 + 40, y2);
        add_point(x2 + 39, y2 + 39);
        add_point(x2 + 40, y2 + 39);
        visit_points();
        report_test("ship_priority", c0, e0);
    endtask

    task automatic test_torpedoes();
        int c0, e0, tx, ty;
        logic [3:0] m1;
        c0 = n_checks;
        e0 = n_errors;
        write_ship(0, 10'd600, 10'd440);   // Ships out of the way
        write_ship(1, 10'd560, 10'd440);
        for (int p = 0; p < 2; p++)
            for (int i = 0; i < `N_TORP; i++)
                write_torp(p, i, coord_t'(100 + 24 * i), coord_t'(300 + 40 * p));
        m1 = 4'($urandom % 16);
        if (m1 == 4'h0 || m1 == 4'hF)
            m1 = 4'b0110;
        write_mask(0, m1);
        write_mask(1, ~m1);
        for (int p = 0; p < 2; p++)
            for (int i = 0; i < `N_TORP; i++) begin
                tx = 100 + 24 * i;
                ty = 300 + 40 * p;
                add_point(tx + 3, ty + 3);
                add_point(tx + 7, ty + 7);
                add_point(tx + 8, ty);
            end
        visit_points();
        report_test("torpedoes", c0, e0);
    endtask

    task automatic test_hex();
        int c0, e0;
        arena_word_u w;
        coord_t val;
        c0 = n_checks;
        e0 = n_errors;
        repeat (3) begin
            val     = coord_t'($urandom % 1024);
            w.coord = val;
            write_reg(`ADDR_SHIP1_X, w);
            sh_ship_x[0] = val;
            @(negedge Clk);
            check_seg("hex0", hex0, seg_pattern(val[3:0]));
            check_seg("hex1", hex1, seg_pattern(val[7:4]));
            check_coord("ship1_x low byte via hex", {2'b00, seg_value(hex1), seg_value(hex0)},
                        {2'b00, val[7:0]});
        end
        report_test("hex", c0, e0);
    endtask

    // --------------------
    initial begin
        arst_n    = 1'b0;
        reg_we    = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        n_checks  = 0;
        n_errors  = 0;
        n_pts     = 0;
        void'($urandom(41));
        for (int p = 0; p < 2; p++) begin
            sh_ship_x[p] = '0;
            sh_ship_y[p] = '0;
            sh_off[p]    = '0;
            for (int i = 0; i < `N_TORP; i++) begin
                sh_torp_x[p][i] = '0;
                sh_torp_y[p][i] = '0;
            end
        end
        test_reset_sync();
        test_background();
        test_ship_priority();
        test_torpedoes();
        test_hex();
        $display("Total: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

    // Watchdog allows four frames per test plus margin
    initial begin
        repeat (WATCHDOG_CYC) @(posedge Clk);
        $display("Timeout: run still going after %0d clock cycles", WATCHDOG_CYC);
        $display("Checks failed");
        $finish;
    end

endmodule

//--- source/arena_top.sv
// Arena top level
// Raster timing, game registers, two player layers, mixer and hex digits
`timescale 1ns/1ps
`include "arena_defs.svh"

module arena_top import arena_pkg::*; (
    input  logic        Clk,
    input  logic        arst_n,
    input  logic        reg_we,
    input  logic [4:0]  reg_addr,
    input  arena_word_u reg_wdata,
    output logic [7:0]  vga_r,
    output logic [7:0]  vga_g,
    output logic [7:0]  vga_b,
    output logic        vga_hs,
    output logic        vga_vs,
    output logic        vga_blank_n,
    output logic [6:0]  hex0,
    output logic [6:0]  hex1
);

    coord_t     draw_x, draw_y;
    logic       hs_raw, vs_raw, visible;

    coord_t     ship1_x, ship1_y, ship2_x, ship2_y;
    coord_t     torp1_x [`N_TORP];
    coord_t     torp1_y [`N_TORP];
    coord_t     torp2_x [`N_TORP];
    coord_t     torp2_y [`N_TORP];
    logic [3:0] torp1_off, torp2_off;

    logic       ship1_hit, torp1_hit;
    logic       ship2_hit, torp2_hit;

    // --------------------
    vga_timing u_vga_timing (
        .Clk     (Clk),
        .arst_n  (arst_n),
        .draw_x  (draw_x),
        .draw_y  (draw_y),
        .hs_raw  (hs_raw),
        .vs_raw  (vs_raw),
        .visible (visible)
    );

    game_state_regs u_game_state_regs (
        .Clk       (Clk),
        .arst_n    (arst_n),
        .reg_we    (reg_we),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .ship1_x   (ship1_x),
        .ship1_y   (ship1_y),
        .ship2_x   (ship2_x),
        .ship2_y   (ship2_y),
        .torp1_x   (torp1_x),
        .torp1_y   (torp1_y),
        .torp2_x   (torp2_x),
        .torp2_y   (torp2_y),
        .torp1_off (torp1_off),
        .torp2_off (torp2_off)
    );

    // --------------------
    // One layer per player
    player_layer u_layer1 (
        .draw_x   (draw_x),
        .draw_y   (draw_y),
        .ship_x   (ship1_x),
        .ship_y   (ship1_y),
        .torp_x   (torp1_x),
        .torp_y   (torp1_y),
        .torp_off (torp1_off),
        .ship_hit (ship1_hit),
        .torp_hit (torp1_hit)
    );

    player_layer u_layer2 (
        .draw_x   (draw_x),
        .draw_y   (draw_y),
        .ship_x   (ship2_x),
        .ship_y   (ship2_y),
        .torp_x   (torp2_x),
        .torp_y   (torp2_y),
        .torp_off (torp2_off),
        .ship_hit (ship2_hit),
        .torp_hit (torp2_hit)
    );

    pixel_mixer u_pixel_mixer (
        .Clk         (Clk),
        .arst_n      (arst_n),
        .visible     (visible),
        .hs_raw      (hs_raw),
        .vs_raw      (vs_raw),
        .ship1_hit   (ship1_hit),
        .ship2_hit   (ship2_hit),
        .torp1_hit   (torp1_hit),
        .torp2_hit   (torp2_hit),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b),
        .vga_hs      (vga_hs),
        .vga_vs      (vga_vs),
        .vga_blank_n (vga_blank_n)
    );

    // Ship 1 x, low byte
    seven_seg_decoder u_hex0 (.nibble(ship1_x[3:0]), .segments(hex0));
    seven_seg_decoder u_hex1 (.nibble(ship1_x[7:4]), .segments(hex1));

endmodule

//--- source/seven_seg_decoder.sv
// Hex digit decoder, active-low segments, bit 0 is segment a
`timescale 1ns/1ps

module seven_seg_decoder (
    input  logic [3:0] nibble,
    output logic [6:0] segments
);

    always_comb begin
        unique case (nibble)
            4'h0: segments = 7'b1000000;
            4'h1: segments = 7'b1111001;
            4'h2: segments = 7'b0100100;
            4'h3: segments = 7'b0110000;
            4'h4: segments = 7'b0011001;
            4'h5: segments = 7'b0010010;
            4'h6: segments = 7'b0000010;
            4'h7: segments = 7'b1111000;
            4'h8: segments = 7'b0000000;
            4'h9: segments = 7'b0010000;
            4'hA: segments = 7'b0001000;
            4'hB: segments = 7'b0000011;   // Lower case b
            4'hC: segments = 7'b1000110;
            4'hD: segments = 7'b0100001;   // Lower case d
            4'hE: segments = 7'b0000110;
            4'hF: segments = 7'b0001110;
        endcase
    end

endmodule

//--- source/pixel_mixer.sv
// Pixel mixer
// Fixed-priority colour pick and the registered VGA output stage
`timescale 1ns/1ps
`include "arena_defs.svh"

module pixel_mixer (
    input  logic       Clk,
    input  logic       arst_n,
    input  logic       visible,
    input  logic       hs_raw,
    input  logic       vs_raw,
    input  logic       ship1_hit,
    input  logic       ship2_hit,
    input  logic       torp1_hit,
    input  logic       torp2_hit,
    output logic [7:0] vga_r,
    output logic [7:0] vga_g,
    output logic [7:0] vga_b,
    output logic       vga_hs,
    output logic       vga_vs,
    output logic       vga_blank_n
);

    logic [23:0] color;
    logic [23:0] rgb_next;

    // --------------------
    // Priority, ship 1 on top
    always_comb begin
        if (ship1_hit)
            color = `COLOR_SHIP1;
        else if (ship2_hit)
            color = `COLOR_SHIP2;
        else if (torp1_hit)
            color = `COLOR_TORP1;
        else if (torp2_hit)
            color = `COLOR_TORP2;
        else
            color = `COLOR_BG;
    end

    assign rgb_next = visible ? color : 24'h000000;   // Black in blanking

    // --------------------
    // Colour, sync and blank leave together
    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            vga_r       <= '0;
            vga_g       <= '0;
            vga_b       <= '0;
            vga_hs      <= 1'b1;   // Inactive
            vga_vs      <= 1'b1;
            vga_blank_n <= 1'b0;
        end else begin
            vga_r       <= rgb_next[23:16];
            vga_g       <= rgb_next[15:8];
            vga_b       <= rgb_next[7:0];
            vga_hs      <= hs_raw;
            vga_vs      <= vs_raw;
            vga_blank_n <= visible;
        end
    end

endmodule

//--- source/player_layer.sv
// Player layer
// Box hit tests for one ship and its torpedoes at the current pixel
`timescale 1ns/1ps
`include "arena_defs.svh"

module player_layer import arena_pkg::*; (
    input  coord_t     draw_x,
    input  coord_t     draw_y,
    input  coord_t     ship_x,
    input  coord_t     ship_y,
    input  coord_t     torp_x [`N_TORP],
    input  coord_t     torp_y [`N_TORP],
    input  logic [3:0] torp_off,
    output logic       ship_hit,
    output logic       torp_hit
);

    // True when pix lies in [base, base+size-1]
    // 11-bit limit so a box past 1023 is clipped, never wrapped
    function automatic logic in_span(coord_t pix, coord_t base, int unsigned size);
        logic [10:0] lim;
        lim = {1'b0, base} + 11'(size);
        return (pix >= base) && ({1'b0, pix} < lim);
    endfunction

    assign ship_hit = in_span(draw_x, ship_x, `SHIP_SIZE) &&
                      in_span(draw_y, ship_y, `SHIP_SIZE);

    // --------------------
    // Torpedoes, OR over the live ones
    always_comb begin
        torp_hit = 1'b0;
        for (int i = 0; i < `N_TORP; i++) begin
            if (!torp_off[i] &&
                in_span(draw_x, torp_x[i], `TORP_SIZE) &&
                in_span(draw_y, torp_y[i], `TORP_SIZE))
                torp_hit = 1'b1;
        end
    end

endmodule

//--- source/game_state_regs.sv
// Game state register file
// Ship and torpedo positions plus torpedo-off masks for both players
`timescale 1ns/1ps
`include "arena_defs.svh"

module game_state_regs import arena_pkg::*; (
    input  logic        Clk,
    input  logic        arst_n,
    input  logic        reg_we,
    input  logic [4:0]  reg_addr,
    input  arena_word_u reg_wdata,
    output coord_t      ship1_x,
    output coord_t      ship1_y,
    output coord_t      ship2_x,
    output coord_t      ship2_y,
    output coord_t      torp1_x [`N_TORP],
    output coord_t      torp1_y [`N_TORP],
    output coord_t      torp2_x [`N_TORP],
    output coord_t      torp2_y [`N_TORP],
    output logic [3:0]  torp1_off,
    output logic [3:0]  torp2_off
);

    localparam int TI_W = $clog2(`N_TORP);

    // Index 0 is player 1, index 1 is player 2
    coord_t     ship_x_q  [2];
    coord_t     ship_y_q  [2];
    coord_t     torp_x_q  [2][`N_TORP];
    coord_t     torp_y_q  [2][`N_TORP];
    logic [3:0] torp_off_q [2];

    logic       pl;
    logic [4:0] offs;       // Address relative to the player's base
    logic [4:0] tx_idx;
    logic [4:0] ty_idx;
    logic       tx_hit;
    logic       ty_hit;

    // --------------------
    // Address decode
    assign pl     = reg_addr[4];
    assign offs   = reg_addr - (pl ? `ADDR_SHIP2_X : `ADDR_SHIP1_X);
    assign tx_idx = offs - `ADDR_TORP1_X;
    assign ty_idx = offs - `ADDR_TORP1_Y;
    assign tx_hit = (offs >= `ADDR_TORP1_X) && (offs < `ADDR_TORP1_X + `N_TORP);
    assign ty_hit = (offs >= `ADDR_TORP1_Y) && (offs < `ADDR_TORP1_Y + `N_TORP);

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int p = 0; p < 2; p++) begin
                ship_x_q[p]   <= '0;
                ship_y_q[p]   <= '0;
                torp_off_q[p] <= '0;
                for (int t = 0; t < `N_TORP; t++) begin
                    torp_x_q[p][t] <= '0;
                    torp_y_q[p][t] <= '0;
                end
            end
        end else if (reg_we) begin
            if (offs == `ADDR_SHIP1_X)
                ship_x_q[pl] <= reg_wdata.coord;
            else if (offs == `ADDR_SHIP1_Y)
                ship_y_q[pl] <= reg_wdata.coord;
            else if (tx_hit)
                torp_x_q[pl][tx_idx[TI_W-1:0]] <= reg_wdata.coord;
            else if (ty_hit)
                torp_y_q[pl][ty_idx[TI_W-1:0]] <= reg_wdata.coord;
            else if (offs == `ADDR_MASK1)
                torp_off_q[pl] <= reg_wdata.mask.torp_off;   // Mask view
            // Anything else is dropped
        end
    end

    // --------------------
    assign ship1_x   = ship_x_q[0];
    assign ship1_y   = ship_y_q[0];
    assign ship2_x   = ship_x_q[1];
    assign ship2_y   = ship_y_q[1];
    assign torp1_x   = torp_x_q[0];
    assign torp1_y   = torp_y_q[0];
    assign torp2_x   = torp_x_q[1];
    assign torp2_y   = torp_y_q[1];
    assign torp1_off = torp_off_q[0];
    assign torp2_off = torp_off_q[1];

endmodule

//--- source/vga_timing.sv
// VGA raster timing
// Pixel counters with sync and visible-area decode
`timescale 1ns/1ps
`include "arena_defs.svh"

module vga_timing import arena_pkg::*; (
    input  logic   Clk,
    input  logic   arst_n,
    output coord_t draw_x,
    output coord_t draw_y,
    output logic   hs_raw,     // Active low
    output logic   vs_raw,     // Active low
    output logic   visible
);

    // Sync windows
    localparam int HS_START = `H_VISIBLE + `H_FRONT;
    localparam int HS_END   = HS_START + `H_SYNC;
    localparam int VS_START = `V_VISIBLE + `V_FRONT;
    localparam int VS_END   = VS_START + `V_SYNC;

    coord_t h_cnt;
    coord_t v_cnt;
    logic   h_last;
    logic   v_last;

    assign h_last = (h_cnt == coord_t'(`H_TOTAL - 1));
    assign v_last = (v_cnt == coord_t'(`V_TOTAL - 1));

    // --------------------
    // Raster counters, x first then y
    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_last) begin
            h_cnt <= '0;
            if (v_last)
                v_cnt <= '0;         // End of frame
            else
                v_cnt <= v_cnt + 1'b1;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // --------------------
    // Decode straight from the counters
    assign draw_x  = h_cnt;
    assign draw_y  = v_cnt;

    assign hs_raw  = !((h_cnt >= HS_START) && (h_cnt < HS_END));
    assign vs_raw  = !((v_cnt >= VS_START) && (v_cnt < VS_END));
    assign visible = (h_cnt < `H_VISIBLE) && (v_cnt < `V_VISIBLE);

endmodule

//--- source/arena_pkg.sv
// Arena shared types
// Screen coordinate and the register write word
package arena_pkg;

    // Screen coordinate, 0..1023
    typedef logic [9:0] coord_t;

    // Torpedo-off mask register layout
    typedef struct packed {
        logic [5:0] unused;
        logic [3:0] torp_off;   // Bit i hides torpedo i
    } torp_mask_t;

    // --------------------
    // One write word, two decodes
    // Position addresses read it as a coordinate,
    // mask addresses read it as the torpedo-off mask
    typedef union packed {
        coord_t     coord;
        torp_mask_t mask;
    } arena_word_u;

endpackage

//--- source/arena_defs.svh
// Arena game constants
// Raster timing, sprite sizes, register map and palette
`ifndef ARENA_DEFS_SVH
`define ARENA_DEFS_SVH

// --------------------
// 640x480 raster, one pixel per Clk
`define H_VISIBLE 640
`define H_FRONT   16
`define H_SYNC    96
`define H_BACK    48
`define H_TOTAL   (`H_VISIBLE + `H_FRONT + `H_SYNC + `H_BACK)

`define V_VISIBLE 480
`define V_FRONT   10
`define V_SYNC    2
`define V_BACK    33
`define V_TOTAL   (`V_VISIBLE + `V_FRONT + `V_SYNC + `V_BACK)

// Box sides in pixels
`define SHIP_SIZE 40
`define TORP_SIZE 8
`define N_TORP    4

// --------------------
// Register map, addr[4] picks the player
`define ADDR_SHIP1_X 5'd0
`define ADDR_SHIP1_Y 5'd1
`define ADDR_TORP1_X 5'd2    // 2..5
`define ADDR_TORP1_Y 5'd6    // 6..9
`define ADDR_MASK1   5'd10
`define ADDR_SHIP2_X 5'd16
`define ADDR_SHIP2_Y 5'd17
`define ADDR_TORP2_X 5'd18   // 18..21
`define ADDR_TORP2_Y 5'd22   // 22..25
`define ADDR_MASK2   5'd26

// Palette, 24-bit RGB
`define COLOR_SHIP1 24'hFF2020
`define COLOR_SHIP2 24'h2040FF
`define COLOR_TORP1 24'hFFC000
`define COLOR_TORP2 24'h00E0E0
`define COLOR_BG    24'h101830

`endif
